// File: files.f
design/core_types_pkg.sv
design/pipe_bus_pkg.sv
design/phys_regfile.sv
design/operand_read.sv
design/retire_report.sv
design/regread_commit_top.sv
verification/regread_commit_assertions.sv
verification/regread_commit_tb.sv

// File: verification/regread_commit_tb.sv
// Register read and commit testbench
// Random CDB traffic, issue requests and retire slots from a fixed
// seed, checked every cycle against a register file model
module regread_commit_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import core_types_pkg::*;
  import pipe_bus_pkg::*;

  localparam int WAYS         = 2;
  localparam int RESET_CYCLES = 8;
  localparam int RUN_CYCLES   = 2000;
  localparam int TIMEOUT_NS   = (RESET_CYCLES + RUN_CYCLES + 20) * 100;

  logic                  clock;
  logic                  rst_n;
  logic                  flush;
  cdb_t       [WAYS-1:0] cdb;
  issue_req_t [WAYS-1:0] issue_req;
  retire_t    [WAYS-1:0] retire;
  issue_t     [WAYS-1:0] issue;
  commit_t    [WAYS-1:0] commit;
  count_t                completed_insts;
  status_t               error_status;

  data_t             model_regs [PRF_SIZE];  // Reference register file
  issue_t [WAYS-1:0] exp_issue;
  integer            seed;
  int                errors;
  int                checks;

  regread_commit_top #(.WAYS(WAYS)) dut0 (
    .clock           (clock),
    .rst_n           (rst_n),
    .flush           (flush),
    .cdb             (cdb),
    .issue_req       (issue_req),
    .retire          (retire),
    .issue           (issue),
    .commit          (commit),
    .completed_insts (completed_insts),
    .error_status    (error_status)
  );

  initial clock = 1'b0;
  always #50 clock = ~clock;

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Zero reg, then the oldest matching CDB way, then the model
  function automatic data_t expected_operand(input preg_idx_t idx);
    if (idx == ZERO_PRF)
      return '0;
    for (int w = 0; w < WAYS; w++)
    begin
      if (cdb[w].valid && (cdb[w].tag == idx))
        return cdb[w].value;
    end
    return model_regs[idx];
  endfunction

  function automatic count_t expected_count();
    int first_bad;
    int n;
    first_bad = WAYS;
    for (int w = WAYS-1; w >= 0; w--)
    begin
      if (retire[w].valid && retire[w].illegal)
        first_bad = w;  // Lowest illegal slot ends the count
    end
    n = 0;
    for (int w = 0; w < first_bad; w++)
    begin
      if (retire[w].valid)
        n++;
    end
    return count_t'(n);
  endfunction

  function automatic status_t expected_status();
    for (int w = 0; w < WAYS; w++)
    begin
      if (retire[w].valid && (retire[w].ir == HALT_INST))
        return HALTED_ON_HALT;
      if (retire[w].valid && retire[w].illegal)
        return HALTED_ON_ILLEGAL;
    end
    return NO_ERROR;
  endfunction

  task automatic predict_issue();
    for (int w = 0; w < WAYS; w++)
    begin
      exp_issue[w].valid   = issue_req[w].valid && !flush;
      exp_issue[w].pdest   = issue_req[w].pdest;
      exp_issue[w].a_value = expected_operand(issue_req[w].prega);
      exp_issue[w].b_value = expected_operand(issue_req[w].pregb);
    end
  endtask

  // Ascending ways, so the higher way wins a tag collision
  task automatic update_model();
    for (int w = 0; w < WAYS; w++)
    begin
      if (cdb[w].valid && (cdb[w].tag != ZERO_PRF))
        model_regs[cdb[w].tag] = cdb[w].value;
    end
  endtask

  //////////////////////////////
  // Stimulus and checks
  //////////////////////////////
  task automatic compare_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("CHECK FAILED %s at %0t: expected %h, actual %h", name, $time, expected, actual);
    end
  endtask

  // Mostly 0..7 with the zero reg now and then, so CDB hits are common
  task automatic draw_index(output preg_idx_t idx);
    int r;
    r = $random(seed);
    idx = (r[3:0] >= 4'd14) ? ZERO_PRF : preg_idx_t'(r[6:4]);
  endtask

  task automatic clear_inputs();
    flush     = 1'b0;
    cdb       = '0;
    issue_req = '0;
    retire    = '0;
  endtask

  task automatic drive_inputs();
    int r;
    flush = (($random(seed) & 15) == 0);  // About one in sixteen
    for (int w = 0; w < WAYS; w++)
    begin
      cdb[w].valid = (($random(seed) & 1) != 0);
      draw_index(cdb[w].tag);
      cdb[w].value = data_t'({$random(seed), $random(seed)});
      issue_req[w].valid = (($random(seed) & 3) != 0);
      draw_index(issue_req[w].prega);
      draw_index(issue_req[w].pregb);
      draw_index(issue_req[w].pdest);
      retire[w].valid   = (($random(seed) & 3) != 0);
      retire[w].illegal = (($random(seed) & 7) == 0);
      r = $random(seed);
      retire[w].ir    = ($unsigned(r) % 10 == 0) ? HALT_INST : inst_t'($random(seed));
      retire[w].npc   = data_t'({$random(seed), $random(seed)});
      draw_index(retire[w].pdest);
      retire[w].adest = areg_idx_t'($random(seed));
    end
  endtask

  task automatic check_outputs();
    for (int w = 0; w < WAYS; w++)
    begin
      compare_value($sformatf("issue[%0d].valid", w), exp_issue[w].valid, issue[w].valid);
      if (exp_issue[w].valid)
      begin
        compare_value($sformatf("issue[%0d].pdest", w), exp_issue[w].pdest, issue[w].pdest);
        compare_value($sformatf("issue[%0d].a_value", w), exp_issue[w].a_value,
                      issue[w].a_value);
        compare_value($sformatf("issue[%0d].b_value", w), exp_issue[w].b_value,
                      issue[w].b_value);
      end
      compare_value($sformatf("commit[%0d].wr_en", w),
                    retire[w].valid && (retire[w].pdest != ZERO_PRF), commit[w].wr_en);
      compare_value($sformatf("commit[%0d].wr_idx", w), retire[w].adest, commit[w].wr_idx);
      compare_value($sformatf("commit[%0d].wr_data", w),
                    (retire[w].pdest == ZERO_PRF) ? '0 : model_regs[retire[w].pdest],
                    commit[w].wr_data);
      compare_value($sformatf("commit[%0d].npc", w), retire[w].npc, commit[w].npc);
      compare_value($sformatf("commit[%0d].ir", w), retire[w].ir, commit[w].ir);
    end
    compare_value("completed_insts", expected_count(), completed_insts);
    compare_value("error_status", expected_status(), error_status);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial
  begin
    seed   = 32'h8a174d61;
    errors = 0;
    checks = 0;
    rst_n  = 1'b0;
    clear_inputs();
    for (int w = 0; w < WAYS; w++)
      issue_req[w].valid = 1'b1;  // Requests pending through reset
    foreach (model_regs[i])
      model_regs[i] = '0;
    repeat (RESET_CYCLES) @(negedge clock);
    for (int w = 0; w < WAYS; w++)
      compare_value($sformatf("reset issue[%0d].valid", w), 1'b0, issue[w].valid);
    rst_n = 1'b1;
    repeat (RUN_CYCLES)
    begin
      @(posedge clock);
      predict_issue();  // Uses the model before this edge's writes
      update_model();
      @(negedge clock);
      check_outputs();
      drive_inputs();
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("TB FAILED");
    $finish;
  end

endmodule

// File: verification/regread_commit_assertions.sv
// Register read and commit assertions
// Flush squash of the issue register, completed count bound, and
// qualification of commit writes and status by the retire slots
module regread_commit_assertions #(
  parameter int WAYS = 2
) (
  input logic                                clock,
  input logic                                rst_n,
  input logic                                flush,
  input pipe_bus_pkg::retire_t    [WAYS-1:0] retire,
  input pipe_bus_pkg::issue_t     [WAYS-1:0] issue,
  input pipe_bus_pkg::commit_t    [WAYS-1:0] commit,
  input core_types_pkg::count_t              completed_insts,
  input core_types_pkg::status_t             error_status
);

  timeunit 1ns;
  timeprecision 100ps;

  import core_types_pkg::*;

  logic [WAYS-1:0] issue_valid;
  logic [WAYS-1:0] retire_valid;

  for (genvar w = 0; w < WAYS; w++)
  begin : g_way
    assign issue_valid[w]  = issue[w].valid;
    assign retire_valid[w] = retire[w].valid;

    wr_en_needs_retire: assert property (@(posedge clock) disable iff (!rst_n)
      commit[w].wr_en |-> retire[w].valid)
      else $error("commit wr_en on way %0d without a valid retire", w);
  end

  flush_clears_issue: assert property (@(posedge clock) disable iff (!rst_n)
    flush |=> (issue_valid == '0))
    else $error("issue valid still set one cycle after a flush");

  count_bounded: assert property (@(posedge clock) disable iff (!rst_n)
    completed_insts <= WAYS)
    else $error("completed_insts %0d exceeds the width", completed_insts);

  // Halt or illegal status only with something retiring
  status_needs_retire: assert property (@(posedge clock) disable iff (!rst_n)
    (error_status != NO_ERROR) |-> (retire_valid != '0))
    else $error("error status set with no valid retire slot");

endmodule

bind regread_commit_top regread_commit_assertions #(.WAYS(WAYS)) asrt0 (
  .clock           (clock),
  .rst_n           (rst_n),
  .flush           (flush),
  .retire          (retire),
  .issue           (issue),
  .commit          (commit),
  .completed_insts (completed_insts),
  .error_status    (error_status)
);

// File: design/regread_commit_top.sv
// Register read and commit top level
// Physical register file with the operand read stage in front of
// execute and the retire report behind the ROB. The first 2*WAYS
// read ports serve operand reads, the last WAYS serve commit.
module regread_commit_top #(
  parameter int WAYS = 2
) (
  input  logic                                clock,
  input  logic                                rst_n,
  input  logic                                flush,      // Mispredict pulse
  input  pipe_bus_pkg::cdb_t       [WAYS-1:0] cdb,
  input  pipe_bus_pkg::issue_req_t [WAYS-1:0] issue_req,
  input  pipe_bus_pkg::retire_t    [WAYS-1:0] retire,
  output pipe_bus_pkg::issue_t     [WAYS-1:0] issue,
  output pipe_bus_pkg::commit_t    [WAYS-1:0] commit,
  output core_types_pkg::count_t              completed_insts,
  output core_types_pkg::status_t             error_status
);

  import core_types_pkg::*;

  // Register file read ports, operand reads low, commit reads high
  wire preg_idx_t [3*WAYS-1:0] rf_rd_idx;
  wire data_t     [3*WAYS-1:0] rf_rd_data;

  //////////////////////////////
  // Register file
  //////////////////////////////
  phys_regfile #(.WAYS(WAYS)) prf0 (
    .clock   (clock),
    .rst_n   (rst_n),
    .cdb     (cdb),
    .rd_idx  (rf_rd_idx),
    .rd_data (rf_rd_data)
  );

  //////////////////////////////
  // Operand read
  //////////////////////////////
  operand_read #(.WAYS(WAYS)) opr0 (
    .clock     (clock),
    .rst_n     (rst_n),
    .flush     (flush),
    .issue_req (issue_req),
    .cdb       (cdb),                          // Bypass source
    .rf_idx    (rf_rd_idx[2*WAYS-1:0]),
    .rf_data   (rf_rd_data[2*WAYS-1:0]),
    .issue     (issue)
  );

  //////////////////////////////
  // Retire report
  //////////////////////////////
  retire_report #(.WAYS(WAYS)) rr0 (
    .retire          (retire),
    .rf_idx          (rf_rd_idx[3*WAYS-1:2*WAYS]),
    .rf_data         (rf_rd_data[3*WAYS-1:2*WAYS]),
    .commit          (commit),
    .completed_insts (completed_insts),
    .error_status    (error_status)
  );

endmodule

// File: design/retire_report.sv
// Retire report
// Builds the architectural commit report of each retiring slot,
// counts the completed instructions and derives the halt or illegal
// status. Purely combinational.
module retire_report #(
  parameter int WAYS = 2
) (
  input  pipe_bus_pkg::retire_t     [WAYS-1:0] retire,
  output core_types_pkg::preg_idx_t [WAYS-1:0] rf_idx,
  input  core_types_pkg::data_t     [WAYS-1:0] rf_data,
  output pipe_bus_pkg::commit_t     [WAYS-1:0] commit,
  output core_types_pkg::count_t               completed_insts,
  output core_types_pkg::status_t              error_status
);

  import core_types_pkg::*;

  logic [WAYS-1:0] is_halt;
  logic [WAYS-1:0] is_illegal;

  for (genvar w = 0; w < WAYS; w++)
  begin : g_flags
    assign is_halt[w]    = retire[w].valid && (retire[w].ir == HALT_INST);
    assign is_illegal[w] = retire[w].valid && retire[w].illegal;
  end

  //////////////////////////////
  // Commit slots
  //////////////////////////////
  always_comb
  begin
    for (int w = 0; w < WAYS; w++)
    begin
      rf_idx[w]         = retire[w].pdest;   // Value at pdest for writeback
      commit[w].wr_en   = retire[w].valid && (retire[w].pdest != ZERO_PRF);
      commit[w].wr_idx  = retire[w].adest;
      commit[w].wr_data = rf_data[w];
      commit[w].npc     = retire[w].npc;
      commit[w].ir      = retire[w].ir;
    end
  end

  //////////////////////////////
  // Completed count and status
  //////////////////////////////

  // Valid slots older than the first illegal one
  always_comb
  begin : count_scan
    logic stop;
    completed_insts = '0;
    stop = 1'b0;
    for (int w = 0; w < WAYS; w++)
    begin
      if (is_illegal[w])
        stop = 1'b1;
      else if (retire[w].valid && !stop)
        completed_insts = completed_insts + count_t'(1);
    end
  end

  // First qualifying slot from way 0 decides, halt ahead of illegal
  always_comb
  begin : status_scan
    logic found;
    error_status = NO_ERROR;
    found = 1'b0;
    for (int w = 0; w < WAYS; w++)
    begin
      if (!found && (is_halt[w] || is_illegal[w]))
      begin
        found = 1'b1;
        error_status = is_halt[w] ? HALTED_ON_HALT : HALTED_ON_ILLEGAL;
      end
    end
  end

endmodule

// File: design/operand_read.sv
// Operand read stage
// Reads both source operands of every issue way from the register
// file, bypasses results from the CDB, and loads the issue register.
// Latency is one cycle. Flush or reset drops every issue valid.
module operand_read #(
  parameter int WAYS = 2
) (
  input  logic                                   clock,
  input  logic                                   rst_n,
  input  logic                                   flush,
  input  pipe_bus_pkg::issue_req_t  [WAYS-1:0]   issue_req,
  input  pipe_bus_pkg::cdb_t        [WAYS-1:0]   cdb,
  output core_types_pkg::preg_idx_t [2*WAYS-1:0] rf_idx,
  input  core_types_pkg::data_t     [2*WAYS-1:0] rf_data,
  output pipe_bus_pkg::issue_t      [WAYS-1:0]   issue
);

  import core_types_pkg::*;
  import pipe_bus_pkg::*;

  data_t     [WAYS-1:0] a_next;
  data_t     [WAYS-1:0] b_next;
  logic      [WAYS-1:0] valid_q;
  preg_idx_t [WAYS-1:0] pdest_q;
  data_t     [WAYS-1:0] a_q;
  data_t     [WAYS-1:0] b_q;

  // Zero reg first, then lowest matching CDB way, then the file
  function automatic data_t pick_operand(input preg_idx_t idx, input data_t rf_value,
                                         input cdb_t [WAYS-1:0] bus);
    data_t value;
    value = rf_value;
    for (int w = WAYS-1; w >= 0; w--)  // Walk down so way 0 wins
    begin
      if (bus[w].valid && (bus[w].tag == idx))
        value = bus[w].value;
    end
    if (idx == ZERO_PRF)
      value = '0;
    return value;
  endfunction

  //////////////////////////////
  // Register file reads
  //////////////////////////////
  for (genvar w = 0; w < WAYS; w++)
  begin : g_rd
    assign rf_idx[2*w]   = issue_req[w].prega;
    assign rf_idx[2*w+1] = issue_req[w].pregb;
  end

  always_comb
  begin
    for (int w = 0; w < WAYS; w++)
    begin
      a_next[w] = pick_operand(issue_req[w].prega, rf_data[2*w], cdb);
      b_next[w] = pick_operand(issue_req[w].pregb, rf_data[2*w+1], cdb);
    end
  end

  //////////////////////////////
  // Issue register
  //////////////////////////////
  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
      valid_q <= '0;
    else if (flush)
      valid_q <= '0;  // Mispredict squash
    else
    begin
      for (int w = 0; w < WAYS; w++)
        valid_q[w] <= issue_req[w].valid;
    end
  end

  // Payload only, qualified by valid_q
  always_ff @(posedge clock)
  begin
    for (int w = 0; w < WAYS; w++)
    begin
      pdest_q[w] <= issue_req[w].pdest;
      a_q[w]     <= a_next[w];
      b_q[w]     <= b_next[w];
    end
  end

  always_comb
  begin
    for (int w = 0; w < WAYS; w++)
    begin
      issue[w].valid   = valid_q[w];
      issue[w].pdest   = pdest_q[w];
      issue[w].a_value = a_q[w];
      issue[w].b_value = b_q[w];
    end
  end

endmodule

// File: design/phys_regfile.sv
// Physical register file
// 64 words, one write port per CDB way and 3 read ports per way.
// Reads are combinational and see only values written at an earlier
// edge. The zero register always reads as zero.
module phys_regfile #(
  parameter int WAYS = 2
) (
  input  logic                                   clock,
  input  logic                                   rst_n,
  input  pipe_bus_pkg::cdb_t        [WAYS-1:0]   cdb,
  input  core_types_pkg::preg_idx_t [3*WAYS-1:0] rd_idx,
  output core_types_pkg::data_t     [3*WAYS-1:0] rd_data
);

  import core_types_pkg::*;

  data_t regs [PRF_SIZE];

  //////////////////////////////
  // Write ports
  //////////////////////////////

  // Later way overwrites earlier on a tag collision
  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < PRF_SIZE; i++)
      begin
        regs[i] <= '0;
      end
    end
    else
    begin
      for (int w = 0; w < WAYS; w++)
      begin
        if (cdb[w].valid && (cdb[w].tag != ZERO_PRF))  // Zero reg ignores writes
        begin
          regs[cdb[w].tag] <= cdb[w].value;
        end
      end
    end
  end

  //////////////////////////////
  // Read ports
  //////////////////////////////

  // No write-through, so same-cycle CDB data is not visible here
  for (genvar r = 0; r < 3*WAYS; r++)
  begin : g_read
    assign rd_data[r] = (rd_idx[r] == ZERO_PRF) ? '0 : regs[rd_idx[r]];
  end

endmodule

// File: design/pipe_bus_pkg.sv
// Pipeline bus structures
// Common data bus, issue request and issue slot, and the
// retire and commit slots seen at the back of the core
package pipe_bus_pkg;

  import core_types_pkg::*;

  // One completed result on the CDB
  typedef struct packed {
    logic      valid;
    preg_idx_t tag;
    data_t     value;
  } cdb_t;

  // Instruction leaving the reservation station
  typedef struct packed {
    logic      valid;
    preg_idx_t prega;
    preg_idx_t pregb;
    preg_idx_t pdest;
  } issue_req_t;

  // One slot of the issue register
  typedef struct packed {
    logic      valid;
    preg_idx_t pdest;
    data_t     a_value;
    data_t     b_value;
  } issue_t;

  // Slot retiring from the ROB
  typedef struct packed {
    logic      valid;
    logic      illegal;
    inst_t     ir;
    data_t     npc;
    preg_idx_t pdest;
    areg_idx_t adest;
  } retire_t;

  // Architectural commit report
  typedef struct packed {
    logic      wr_en;
    areg_idx_t wr_idx;
    data_t     wr_data;
    data_t     npc;
    inst_t     ir;
  } commit_t;

endpackage

// File: design/core_types_pkg.sv
// Core type definitions
// Machine word and index widths, physical register file size,
// the halt encoding and the retire error status codes
package core_types_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////
  typedef logic [63:0] data_t;      // Machine word
  typedef logic [31:0] inst_t;      // Instruction word
  typedef logic [5:0]  preg_idx_t;  // Physical register index
  typedef logic [4:0]  areg_idx_t;  // Architectural register index
  typedef logic [3:0]  status_t;
  typedef logic [3:0]  count_t;     // Retired per cycle

  // Physical register file
  localparam int PRF_SIZE = 64;

  // Hardwired zero, never written
  localparam preg_idx_t ZERO_PRF = 6'd63;

  // Halt instruction encoding
  localparam inst_t HALT_INST = 32'h0000_0555;

  //////////////////////////////
  // Error status codes
  //////////////////////////////
  localparam status_t NO_ERROR          = 4'd0;
  localparam status_t HALTED_ON_HALT    = 4'd1;
  localparam status_t HALTED_ON_ILLEGAL = 4'd2;

endpackage
